/* common/bus_pkg.sv */
package bus_pkg;

    // phases of a single-beat master access.
    typedef enum logic [2:0] {
        PH_IDLE   = 3'd0,
        PH_REQ    = 3'd1,
        PH_ADDR   = 3'd2,
        PH_WAIT   = 3'd3,
        PH_DATA   = 3'd4,
        PH_FINISH = 3'd5
    } bus_phase_e;

    // access type carried on the shared bus.
    typedef enum logic {
        CMD_READ  = 1'b0,
        CMD_WRITE = 1'b1
    } bus_cmd_e;

endpackage

/* common/cfg_pkg.sv */
package cfg_pkg;

    // word address into the target memory.
    localparam int DEF_ADDR_W = 6;

    localparam int DEF_DATA_W = 16;

    // wait states the target inserts after each address phase.
    localparam int DEF_WAIT_CYCLES = 2;

endpackage

/* bus_interface/cpu_bus_interface.sv */
`timescale 1ns/1ps

module cpu_bus_interface #(
    parameter int ADDR_W = 8,
    parameter int DATA_W = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              op_valid,
    input  bus_pkg::bus_cmd_e op_cmd,
    input  logic [ADDR_W-1:0] op_addr,
    input  logic [DATA_W-1:0] op_wdata,
    output logic              op_ready,
    output logic [DATA_W-1:0] op_rdata,
    output logic              stall,
    output logic              bus_req,
    input  logic              bus_ack,
    input  logic              bus_wait,
    output logic              bus_addr_valid,
    output bus_pkg::bus_cmd_e bus_cmd,
    output logic [ADDR_W-1:0] bus_addr,
    output logic [DATA_W-1:0] bus_wdata,
    input  logic [DATA_W-1:0] bus_rdata
);

    bus_pkg::bus_phase_e phase;
    bus_pkg::bus_phase_e phase_next;

    bus_pkg::bus_cmd_e   cmd_q;
    logic [ADDR_W-1:0]   addr_q;
    logic [DATA_W-1:0]   wdata_q;
    logic [DATA_W-1:0]   rdata_q;
    logic                busy_stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= bus_pkg::PH_IDLE;
        end else begin
            phase <= phase_next;
        end
    end

    always_comb begin
        phase_next = phase;
        case (phase)
            bus_pkg::PH_IDLE: begin
                if (op_valid) begin
                    phase_next = bus_pkg::PH_REQ;
                end
            end
            bus_pkg::PH_REQ: begin
                if (bus_ack) begin
                    phase_next = bus_pkg::PH_ADDR;
                end
            end
            bus_pkg::PH_ADDR: begin
                phase_next = bus_pkg::PH_WAIT;
            end
            bus_pkg::PH_WAIT: begin
                if (!bus_wait) begin
                    phase_next = bus_pkg::PH_DATA;
                end
            end
            // single beat only.
            bus_pkg::PH_DATA: begin
                phase_next = bus_pkg::PH_FINISH;
            end
            bus_pkg::PH_FINISH: begin
                phase_next = bus_pkg::PH_IDLE;
            end
            default: begin
                phase_next = bus_pkg::PH_IDLE;
            end
        endcase
    end

    // per-phase output decode.
    always_comb begin
        bus_req        = 1'b0;
        bus_addr_valid = 1'b0;
        busy_stall     = 1'b0;
        op_ready       = 1'b0;
        case (phase)
            bus_pkg::PH_REQ, bus_pkg::PH_WAIT, bus_pkg::PH_DATA: begin
                bus_req    = 1'b1;
                busy_stall = 1'b1;
            end
            bus_pkg::PH_ADDR: begin
                bus_req        = 1'b1;
                bus_addr_valid = 1'b1;
                busy_stall     = 1'b1;
            end
            bus_pkg::PH_FINISH: begin
                op_ready = 1'b1;
            end
            default: begin
                bus_req = 1'b0;
            end
        endcase
    end

    // cpu must freeze in the same cycle it raises valid.
    assign stall = (phase == bus_pkg::PH_IDLE) ? op_valid : busy_stall;

    always_ff @(posedge clk) begin
        if (phase == bus_pkg::PH_IDLE && op_valid) begin
            cmd_q   <= op_cmd;
            addr_q  <= op_addr;
            wdata_q <= op_wdata;
        end
        if (phase == bus_pkg::PH_DATA) begin
            rdata_q <= bus_rdata;
        end
    end

    assign bus_cmd   = cmd_q;
    assign bus_addr  = addr_q;
    assign bus_wdata = wdata_q;
    assign op_rdata  = rdata_q;

endmodule

/* hdl/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic clk,
    input  logic rst_n,
    input  logic req0,
    input  logic req1,
    output logic grant0,
    output logic grant1
);

    // 1 when port 1 held the last grant.
    logic last_owner;
    // a grant was active in the previous cycle.
    logic held;
    logic owner_req;
    logic other_req;

    assign owner_req = last_owner ? req1 : req0;
    assign other_req = last_owner ? req0 : req1;

    always_comb begin
        grant0 = 1'b0;
        grant1 = 1'b0;
        if (held && owner_req) begin
            grant0 = !last_owner;
            grant1 = last_owner;
        end else if (other_req) begin
            // round robin, the other side goes first.
            grant0 = last_owner;
            grant1 = !last_owner;
        end else if (owner_req) begin
            grant0 = !last_owner;
            grant1 = last_owner;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_owner <= 1'b1;
            held       <= 1'b0;
        end else begin
            held <= grant0 | grant1;
            if (grant0 | grant1) begin
                last_owner <= grant1;
            end
        end
    end

endmodule

/* hdl/bus_mem_target.sv */
`timescale 1ns/1ps

module bus_mem_target #(
    parameter int ADDR_W      = 8,
    parameter int DATA_W      = 32,
    parameter int WAIT_CYCLES = 1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              bus_addr_valid,
    input  bus_pkg::bus_cmd_e bus_cmd,
    input  logic [ADDR_W-1:0] bus_addr,
    input  logic [DATA_W-1:0] bus_wdata,
    output logic              bus_wait,
    output logic [DATA_W-1:0] bus_rdata
);

    localparam int DEPTH = 1 << ADDR_W;
    localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

    typedef enum logic [1:0] {
        TGT_IDLE = 2'd0,
        TGT_WAIT = 2'd1,
        TGT_DATA = 2'd2
    } tgt_state_e;

    tgt_state_e        state;
    logic [CNT_W-1:0]  wait_cnt;
    logic [ADDR_W-1:0] addr_q;
    bus_pkg::bus_cmd_e cmd_q;
    logic [DATA_W-1:0] rdata_q;
    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= TGT_IDLE;
            wait_cnt <= '0;
        end else begin
            case (state)
                TGT_IDLE: begin
                    if (bus_addr_valid) begin
                        wait_cnt <= CNT_W'(WAIT_CYCLES);
                        state    <= TGT_WAIT;
                    end
                end
                TGT_WAIT: begin
                    if (wait_cnt != '0) begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end else begin
                        state <= TGT_DATA;
                    end
                end
                TGT_DATA: begin
                    state <= TGT_IDLE;
                end
                default: begin
                    state <= TGT_IDLE;
                end
            endcase
        end
    end

    assign bus_wait = (wait_cnt != '0);

    always_ff @(posedge clk) begin
        if (state == TGT_IDLE && bus_addr_valid) begin
            addr_q <= bus_addr;
            cmd_q  <= bus_cmd;
        end
        // last wait cycle, so data is ready for the master's data phase.
        if (state == TGT_WAIT && wait_cnt == '0) begin
            rdata_q <= mem[addr_q];
        end
        if (state == TGT_DATA && cmd_q == bus_pkg::CMD_WRITE) begin
            mem[addr_q] <= bus_wdata;
        end
    end

    assign bus_rdata = rdata_q;

endmodule

/* hdl/cpu_bus_subsystem.sv */
`timescale 1ns/1ps

module cpu_bus_subsystem #(
    parameter int ADDR_W      = cfg_pkg::DEF_ADDR_W,
    parameter int DATA_W      = cfg_pkg::DEF_DATA_W,
    parameter int WAIT_CYCLES = cfg_pkg::DEF_WAIT_CYCLES
) (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              cpu0_op_valid,
    input  bus_pkg::bus_cmd_e cpu0_op_cmd,
    input  logic [ADDR_W-1:0] cpu0_op_addr,
    input  logic [DATA_W-1:0] cpu0_op_wdata,
    output logic              cpu0_op_ready,
    output logic [DATA_W-1:0] cpu0_op_rdata,
    output logic              cpu0_stall,

    input  logic              cpu1_op_valid,
    input  bus_pkg::bus_cmd_e cpu1_op_cmd,
    input  logic [ADDR_W-1:0] cpu1_op_addr,
    input  logic [DATA_W-1:0] cpu1_op_wdata,
    output logic              cpu1_op_ready,
    output logic [DATA_W-1:0] cpu1_op_rdata,
    output logic              cpu1_stall
);

    logic              req0, req1;
    logic              grant0, grant1;
    logic              p0_addr_valid, p1_addr_valid;
    bus_pkg::bus_cmd_e p0_cmd, p1_cmd;
    logic [ADDR_W-1:0] p0_addr, p1_addr;
    logic [DATA_W-1:0] p0_wdata, p1_wdata;

    logic              bus_addr_valid;
    bus_pkg::bus_cmd_e bus_cmd;
    logic [ADDR_W-1:0] bus_addr;
    logic [DATA_W-1:0] bus_wdata;
    logic              bus_wait;
    logic [DATA_W-1:0] bus_rdata;

    cpu_bus_interface #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) port0_if (
        .clk(clk), .rst_n(rst_n),
        .op_valid(cpu0_op_valid), .op_cmd(cpu0_op_cmd),
        .op_addr(cpu0_op_addr), .op_wdata(cpu0_op_wdata),
        .op_ready(cpu0_op_ready), .op_rdata(cpu0_op_rdata), .stall(cpu0_stall),
        .bus_req(req0), .bus_ack(grant0), .bus_wait(bus_wait),
        .bus_addr_valid(p0_addr_valid), .bus_cmd(p0_cmd),
        .bus_addr(p0_addr), .bus_wdata(p0_wdata), .bus_rdata(bus_rdata)
    );

    cpu_bus_interface #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) port1_if (
        .clk(clk), .rst_n(rst_n),
        .op_valid(cpu1_op_valid), .op_cmd(cpu1_op_cmd),
        .op_addr(cpu1_op_addr), .op_wdata(cpu1_op_wdata),
        .op_ready(cpu1_op_ready), .op_rdata(cpu1_op_rdata), .stall(cpu1_stall),
        .bus_req(req1), .bus_ack(grant1), .bus_wait(bus_wait),
        .bus_addr_valid(p1_addr_valid), .bus_cmd(p1_cmd),
        .bus_addr(p1_addr), .bus_wdata(p1_wdata), .bus_rdata(bus_rdata)
    );

    bus_arbiter arbiter (
        .clk(clk), .rst_n(rst_n),
        .req0(req0), .req1(req1),
        .grant0(grant0), .grant1(grant1)
    );

    // shared bus follows the grant.
    assign bus_addr_valid = (grant0 & p0_addr_valid) | (grant1 & p1_addr_valid);
    assign bus_cmd        = grant1 ? p1_cmd : p0_cmd;
    assign bus_addr       = grant1 ? p1_addr : p0_addr;
    assign bus_wdata      = grant1 ? p1_wdata : p0_wdata;

    bus_mem_target #(
        .ADDR_W(ADDR_W), .DATA_W(DATA_W), .WAIT_CYCLES(WAIT_CYCLES)
    ) mem_target (
        .clk(clk), .rst_n(rst_n),
        .bus_addr_valid(bus_addr_valid), .bus_cmd(bus_cmd),
        .bus_addr(bus_addr), .bus_wdata(bus_wdata),
        .bus_wait(bus_wait), .bus_rdata(bus_rdata)
    );

endmodule

/* sim/cpu_bus_tb.sv */
`timescale 1ns/1ps

module cpu_bus_tb;

    localparam int ADDR_W          = cfg_pkg::DEF_ADDR_W;
    localparam int DATA_W          = cfg_pkg::DEF_DATA_W;
    localparam int WAIT_CYCLES     = cfg_pkg::DEF_WAIT_CYCLES;
    localparam int RANDOM_OPS      = 400;
    localparam int TOTAL_OPS       = (1 << ADDR_W) + 2 * RANDOM_OPS;
    localparam int WATCHDOG_CYCLES = TOTAL_OPS * (WAIT_CYCLES + 5) * 2 + 200;
    localparam logic [15:0] SEED   = 16'd39003;

    logic              clk;
    logic              rst_n;
    logic [1:0]        op_valid;
    bus_pkg::bus_cmd_e op_cmd [2];
    logic [ADDR_W-1:0] op_addr [2];
    logic [DATA_W-1:0] op_wdata [2];
    wire  [1:0]        op_ready;
    wire  [1:0]        stall;
    wire  [DATA_W-1:0] rdata0;
    wire  [DATA_W-1:0] rdata1;

    logic [15:0]       lfsr [2];
    logic [1:0]        accepted;
    logic [1:0]        waiting;
    logic [1:0]        busy;
    int                lat [2];
    logic [DATA_W-1:0] model_mem [int];
    bit                fill_phase;
    int                errors;
    int                checks;

    cpu_bus_subsystem #(
        .ADDR_W(ADDR_W), .DATA_W(DATA_W), .WAIT_CYCLES(WAIT_CYCLES)
    ) cpu_bus_subsystem_inst (
        .clk(clk), .rst_n(rst_n),
        .cpu0_op_valid(op_valid[0]), .cpu0_op_cmd(op_cmd[0]),
        .cpu0_op_addr(op_addr[0]), .cpu0_op_wdata(op_wdata[0]),
        .cpu0_op_ready(op_ready[0]), .cpu0_op_rdata(rdata0), .cpu0_stall(stall[0]),
        .cpu1_op_valid(op_valid[1]), .cpu1_op_cmd(op_cmd[1]),
        .cpu1_op_addr(op_addr[1]), .cpu1_op_wdata(op_wdata[1]),
        .cpu1_op_ready(op_ready[1]), .cpu1_op_rdata(rdata1), .cpu1_stall(stall[1])
    );

    always #20 clk = ~clk;

    // right shifting form of x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int p, input int nbits, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr[p] = lfsr_next(lfsr[p]);
            val = {val[30:0], lfsr[p][0]};
        end
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic apply_to_model(input int p);
        logic [DATA_W-1:0] got;
        got = p ? rdata1 : rdata0;
        if (op_cmd[p] == bus_pkg::CMD_WRITE) begin
            model_mem[op_addr[p]] = op_wdata[p];
        end else begin
            check_eq(got, model_mem[op_addr[p]],
                     $sformatf("read data on port %0d at address %0h", p, op_addr[p]));
        end
    endtask

    // starts just after a rising edge and returns on the edge that ends the transfer.
    task automatic issue_op(input int p, input bus_pkg::bus_cmd_e cmd,
                            input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        op_valid[p] <= 1'b1;
        op_cmd[p]   <= cmd;
        op_addr[p]  <= addr;
        op_wdata[p] <= data;
        @(posedge clk);
        while (!accepted[p]) begin
            @(posedge clk);
        end
    endtask

    task automatic run_random(input int p, input int n_ops);
        logic [31:0]       r;
        bus_pkg::bus_cmd_e cmd;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        for (int i = 0; i < n_ops; i++) begin
            take_bits(p, 2, r);
            if (r == 0) begin
                op_valid[p] <= 1'b0;
                take_bits(p, 2, r);
                repeat (r + 1) @(posedge clk);
            end
            take_bits(p, 1, r);
            cmd = bus_pkg::bus_cmd_e'(r[0]);
            take_bits(p, ADDR_W, r);
            addr = r[ADDR_W-1:0];
            take_bits(p, DATA_W, r);
            data = r[DATA_W-1:0];
            issue_op(p, cmd, addr, data);
        end
        op_valid[p] <= 1'b0;
    endtask

    // mid-cycle monitor where outputs have settled.
    always @(negedge clk) begin
        int o;
        if (rst_n) begin
            check_eq(op_ready[0] & op_ready[1], 1'b0, "op_ready high on both ports");
            for (int p = 0; p < 2; p++) begin
                o = 1 - p;
                check_eq(stall[p], op_valid[p] & ~op_ready[p],
                         $sformatf("stall on port %0d", p));
                if (op_valid[p] && !busy[p]) begin
                    busy[p] = 1'b1;
                    lat[p]  = 0;
                end else if (busy[p]) begin
                    lat[p]++;
                end
                accepted[p] = op_valid[p] & op_ready[p];
                if (accepted[p]) begin
                    if (fill_phase && p == 0) begin
                        check_eq(lat[p], WAIT_CYCLES + 5, "port 0 latency in fill phase");
                    end
                    // the other port was left waiting at our last transfer.
                    check_eq(waiting[o], 1'b0,
                             $sformatf("port %0d served again while port %0d waited", p, o));
                    waiting[o] = op_valid[o];
                    waiting[p] = 1'b0;
                    busy[p]    = 1'b0;
                    apply_to_model(p);
                end
            end
        end else begin
            accepted = '0;
        end
    end

    initial begin
        bus_pkg::bus_phase_e ph0;
        bus_pkg::bus_phase_e ph1;
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        ph0 = cpu_bus_subsystem_inst.port0_if.phase;
        ph1 = cpu_bus_subsystem_inst.port1_if.phase;
        $display("timeout after %0d cycles, an access never finished", WATCHDOG_CYCLES);
        $display("port 0 stuck in %s and port 1 in %s", ph0.name(), ph1.name());
        $display("errors: %0d, checks: %0d", errors, checks);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        clk         = 1'b0;
        rst_n       = 1'b0;
        op_valid    = 2'b00;
        accepted    = 2'b00;
        waiting     = 2'b00;
        busy        = 2'b00;
        fill_phase  = 1'b0;
        errors      = 0;
        checks      = 0;
        for (int p = 0; p < 2; p++) begin
            op_cmd[p]   = bus_pkg::CMD_READ;
            op_addr[p]  = '0;
            op_wdata[p] = '0;
            lfsr[p]     = SEED;
            lat[p]      = 0;
        end

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_eq(op_ready, 2'b00, "op_ready after reset");
        check_eq(stall, 2'b00, "stall after reset");
        @(posedge clk);

        // fill every word from port 0 alone.
        fill_phase = 1'b1;
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            take_bits(0, DATA_W, r);
            issue_op(0, bus_pkg::CMD_WRITE, ADDR_W'(a), r[DATA_W-1:0]);
            op_valid[0] <= 1'b0;
            @(posedge clk);
        end
        fill_phase = 1'b0;

        fork
            run_random(0, RANDOM_OPS);
            run_random(1, RANDOM_OPS);
        join

        repeat (4) @(posedge clk);
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* src.f */
common/bus_pkg.sv
common/cfg_pkg.sv
bus_interface/cpu_bus_interface.sv
hdl/bus_arbiter.sv
hdl/bus_mem_target.sv
hdl/cpu_bus_subsystem.sv
sim/cpu_bus_tb.sv
